// ==== rtl/fir_settings.svh ====
`ifndef FIR_SETTINGS_SVH
`define FIR_SETTINGS_SVH

// sample and coefficient width, 1s17 outside and 2s16 inside
`define FIR_WIDTH 18

// filter length, must be odd for a single center tap
`define FIR_TAPS 15

// seven symmetric pairs plus the center word
// must be a power of two so the adder tree stays balanced
`define FIR_PAIRS 8

// adder tree depth, log2 of FIR_PAIRS
`define FIR_TREE_LVLS 3

// sys_clk cycles per sample strobe, 2 or more
`define FIR_SAMPLE_DIV 4

// width of the strobe divider counter
`define FIR_DIV_W ($clog2(`FIR_SAMPLE_DIV))

`endif

// ==== rtl/fir_pkg.sv ====
`include "fir_settings.svh"

package fir_pkg;

    // one sample or coefficient
    // 1s17 at the input, 2s16 once captured
    typedef logic signed [`FIR_WIDTH-1:0] sample_t;

    // full precision coefficient times folded sample
    typedef logic signed [2*`FIR_WIDTH-1:0] product_t;

    // folded words for the multipliers
    // element FIR_PAIRS-1 holds the center sample alone
    typedef sample_t [`FIR_PAIRS-1:0] fold_array_t;

endpackage

// ==== rtl/sample_rate_ctl.sv ====
`timescale 1ns/1ps
`include "fir_settings.svh"

module sample_rate_ctl (
    input  logic             sys_clk,
    input  logic             reset,
    input  fir_pkg::sample_t x_in,
    output logic             sam_strobe,
    output fir_pkg::sample_t new_sample
);

    localparam logic [`FIR_DIV_W-1:0] cnt_last = `FIR_DIV_W'(`FIR_SAMPLE_DIV - 1);

    logic [`FIR_DIV_W-1:0] div_cnt;

    // mod FIR_SAMPLE_DIV counter
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            div_cnt <= '0;
        end else if (div_cnt == cnt_last) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // one cycle pulse on the last count
    assign sam_strobe = (div_cnt == cnt_last);

    // halve on capture, 1s17 -> 2s16
    // the extra integer bit keeps the pair sums in range
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            new_sample <= '0;
        end else if (sam_strobe) begin
            new_sample <= x_in >>> 1;
        end
    end

    // every stage downstream relies on a single-cycle enable
    a_strobe_single : assert property (
        @(posedge sys_clk) disable iff (reset)
        sam_strobe |=> !sam_strobe
    );

endmodule

// ==== rtl/fold_delay_line.sv ====
`timescale 1ns/1ps
`include "fir_settings.svh"

module fold_delay_line (
    input  logic                 sys_clk,
    input  logic                 reset,
    input  logic                 sam_strobe,
    input  fir_pkg::sample_t     new_sample,
    output fir_pkg::fold_array_t fold_words
);

    localparam int center = (`FIR_TAPS - 1) / 2;

    // tap 0 is the newest sample
    fir_pkg::sample_t taps [0:`FIR_TAPS-1];

    if ((`FIR_TAPS % 2) != 1 || `FIR_PAIRS != center + 1) begin : g_bad_len
        $error("tap count must be odd and match FIR_PAIRS");
    end

    // shift the whole line once per sample
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            for (int i = 0; i < `FIR_TAPS; i++) begin
                taps[i] <= '0;
            end
        end else if (sam_strobe) begin
            taps[0] <= new_sample;
            for (int i = 1; i < `FIR_TAPS; i++) begin
                taps[i] <= taps[i-1];
            end
        end
    end

    // pre-adder, taps are symmetric around the center
    // so each pair shares one multiplier downstream
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            fold_words <= '0;
        end else if (sam_strobe) begin
            for (int i = 0; i < `FIR_PAIRS - 1; i++) begin
                // no saturation here, overflow wraps
                fold_words[i] <= taps[i] + taps[`FIR_TAPS-1-i];
            end
            fold_words[`FIR_PAIRS-1] <= taps[center];
        end
    end

    // the tree sees zeros right after reset
    a_reset_clears : assert property (
        @(posedge sys_clk)
        reset |=> (fold_words == '0)
    );

endmodule

// ==== rtl/tap_adder_tree.sv ====
`timescale 1ns/1ps
`include "fir_settings.svh"

module tap_adder_tree (
    input  logic                 sys_clk,
    input  logic                 reset,
    input  logic                 sam_strobe,
    input  fir_pkg::fold_array_t fold_words,
    output fir_pkg::sample_t     y
);

    // outer half of a windowed lowpass, center last
    localparam fir_pkg::sample_t coef [0:`FIR_PAIRS-1] = '{
        -81,
        101,
        -156,
        200,
        -247,
        1154,
        -7042,
        40070
    };

    // top product bit is dropped, the rest matches 2s16
    localparam int prod_hi = 2 * `FIR_WIDTH - 2;
    localparam int prod_lo = `FIR_WIDTH - 1;

    fir_pkg::product_t prod  [0:`FIR_PAIRS-1];
    fir_pkg::sample_t  trunc [0:`FIR_PAIRS-1];

    // registered sums, heap order
    // node 1 is the root, node k adds children 2k and 2k+1
    fir_pkg::sample_t  node  [1:`FIR_PAIRS-1];

    if ((1 << `FIR_TREE_LVLS) != `FIR_PAIRS) begin : g_bad_tree
        $error("adder tree needs FIR_PAIRS equal to 2**FIR_TREE_LVLS");
    end

    // one multiplier per folded word
    always_comb begin
        for (int i = 0; i < `FIR_PAIRS; i++) begin
            prod[i]  = coef[i] * $signed(fold_words[i]);
            trunc[i] = prod[i][prod_hi:prod_lo];
        end
    end

    // each level adds one strobe of latency
    // FIR_TREE_LVLS strobes from fold_words to y
    for (genvar k = 1; k < `FIR_PAIRS; k++) begin : g_node
        fir_pkg::sample_t left;
        fir_pkg::sample_t right;

        if (2 * k >= `FIR_PAIRS) begin : g_leaf
            // first level reads the truncated products
            assign left  = trunc[2*k - `FIR_PAIRS];
            assign right = trunc[2*k + 1 - `FIR_PAIRS];
        end else begin : g_inner
            assign left  = node[2*k];
            assign right = node[2*k + 1];
        end

        // sums wrap on overflow
        always_ff @(posedge sys_clk) begin
            if (reset) begin
                node[k] <= '0;
            end else if (sam_strobe) begin
                node[k] <= left + right;
            end
        end
    end

    assign y = node[1];

    // output only moves on a sample edge
    a_y_holds : assert property (
        @(posedge sys_clk) disable iff (reset)
        !sam_strobe |=> $stable(y)
    );

endmodule

// ==== rtl/fir_sym_top.sv ====
`timescale 1ns/1ps

module fir_sym_top (
    input  logic             sys_clk,
    input  logic             reset,
    input  fir_pkg::sample_t x_in,
    output logic             sample_strobe,
    output fir_pkg::sample_t y
);

    logic                 sam_strobe;
    fir_pkg::sample_t     new_sample;
    fir_pkg::fold_array_t fold_words;

    // strobe generation and input capture
    sample_rate_ctl u_sample_rate_ctl (
        .sys_clk    (sys_clk),
        .reset      (reset),
        .x_in       (x_in),
        .sam_strobe (sam_strobe),
        .new_sample (new_sample)
    );

    // delay line and pair folding
    fold_delay_line u_fold_delay_line (
        .sys_clk    (sys_clk),
        .reset      (reset),
        .sam_strobe (sam_strobe),
        .new_sample (new_sample),
        .fold_words (fold_words)
    );

    // multipliers and adder tree
    tap_adder_tree u_tap_adder_tree (
        .sys_clk    (sys_clk),
        .reset      (reset),
        .sam_strobe (sam_strobe),
        .fold_words (fold_words),
        .y          (y)
    );

    // tells the source when x_in is taken
    assign sample_strobe = sam_strobe;

endmodule

// ==== test/tb_fir_sym.sv ====
`timescale 1ns/1ps
`include "fir_settings.svh"

module tb_fir_sym;

    localparam int taps     = `FIR_TAPS;
    localparam int pairs    = `FIR_PAIRS;
    localparam int div      = `FIR_SAMPLE_DIV;
    localparam int latency  = 5;
    localparam int hist_len = latency + taps;

    // strobes per phase
    localparam int imp_lead      = 3;
    localparam int imp_tail      = 22;
    localparam int step_len      = 25;
    localparam int rand_count    = 200;
    localparam int total_strobes = imp_lead + 1 + imp_tail + 2 * step_len + rand_count;
    localparam int timeout_cycles = (3 * total_strobes * div) / 2 + 100;

    // outer half of the lowpass, center last
    localparam int coef_ref [0:pairs-1] = '{-81, 101, -156, 200, -247, 1154, -7042, 40070};

    logic             sys_clk;
    logic             reset;
    fir_pkg::sample_t x_in;
    logic             sample_strobe;
    fir_pkg::sample_t y;

    // halved samples, newest first, deep enough to cover the latency
    fir_pkg::sample_t hist [0:hist_len-1];
    fir_pkg::sample_t exp_y;
    fir_pkg::sample_t exp_imp;
    fir_pkg::sample_t exp_step;
    logic             imp_active;
    logic             step_active;
    logic             step_settled;
    int               strobe_no;
    int               imp_start;
    int               step_start;
    logic [31:0]      rng_state;
    int unsigned      cyc_after_reset;
    int unsigned      cycle_count;
    int               ctl_errs;
    int               hold_errs;
    int               model_errs;
    int               imp_errs;
    int               step_errs;
    int               total_errs;

    fir_sym_top u_fir_sym_top (
        .sys_clk       (sys_clk),
        .reset         (reset),
        .x_in          (x_in),
        .sample_strobe (sample_strobe),
        .y             (y)
    );

    initial begin
        sys_clk = 1'b0;
        forever begin
            #5 sys_clk = ~sys_clk;
        end
    end

    always @(posedge sys_clk) begin
        if (reset) begin
            cyc_after_reset <= 0;
        end else begin
            cyc_after_reset <= cyc_after_reset + 1;
        end
    end

    always @(posedge sys_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: stimulus did not finish within %0d cycles", timeout_cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] r;
        r = s ^ (s << 13);
        r = r ^ (r >> 17);
        r = r ^ (r << 5);
        return r;
    endfunction

    // product bits 34:17 as a signed value
    function automatic longint keep_bits(input int c, input fir_pkg::sample_t f);
        longint p;
        p = longint'(c) * longint'(f);
        return longint'(fir_pkg::sample_t'(p >>> 17));
    endfunction

    // y after the current strobe, taps start latency strobes back
    function automatic fir_pkg::sample_t model_output();
        longint           acc;
        fir_pkg::sample_t f;
        acc = 0;
        for (int i = 0; i < pairs; i++) begin
            if (i < pairs - 1) begin
                f = fir_pkg::sample_t'(hist[latency + i] + hist[latency + taps - 1 - i]);
            end else begin
                f = hist[latency + i];
            end
            acc += keep_bits(coef_ref[i], f);
        end
        return fir_pkg::sample_t'(acc);
    endfunction

    // every tap holds the same halved level h
    function automatic fir_pkg::sample_t settled_output(input fir_pkg::sample_t h);
        longint acc;
        acc = 0;
        for (int i = 0; i < pairs - 1; i++) begin
            acc += keep_bits(coef_ref[i], fir_pkg::sample_t'(h + h));
        end
        acc += keep_bits(coef_ref[pairs-1], h);
        return fir_pkg::sample_t'(acc);
    endfunction

    // half-scale impulse gives coef >>> 2, mirrored around the center
    function automatic fir_pkg::sample_t impulse_expect(input int j);
        int idx;
        if (j < 0 || j >= taps) begin
            return '0;
        end
        idx = (j < pairs) ? j : taps - 1 - j;
        return fir_pkg::sample_t'(coef_ref[idx] >>> 2);
    endfunction

    task automatic update_model(input fir_pkg::sample_t v);
        int k;
        k = strobe_no;
        for (int j = hist_len - 1; j > 0; j--) begin
            hist[j] = hist[j-1];
        end
        hist[0] = fir_pkg::sample_t'(v >>> 1);
        exp_y = model_output();
        if (imp_active) begin
            exp_imp = impulse_expect(k - imp_start - latency);
        end
        if (step_active) begin
            step_settled = (k - step_start >= hist_len - 1);
        end
        if (step_settled) begin
            exp_step = settled_output(hist[0]);
        end
        strobe_no = strobe_no + 1;
    endtask

    // called on a falling edge, returns on the falling edge after capture
    task automatic apply_sample(input fir_pkg::sample_t v);
        x_in = v;
        while (!sample_strobe) begin
            @(negedge sys_clk);
        end
        // the coming rising edge takes v
        update_model(v);
        @(negedge sys_clk);
    endtask

    task automatic run_impulse();
        imp_active = 1'b1;
        imp_start  = strobe_no + imp_lead;
        repeat (imp_lead) apply_sample('0);
        apply_sample(18'sh10000);
        repeat (imp_tail) apply_sample('0);
        imp_active = 1'b0;
    endtask

    task automatic run_step(input fir_pkg::sample_t level);
        step_active = 1'b1;
        step_start  = strobe_no;
        repeat (step_len) apply_sample(level);
        step_active  = 1'b0;
        step_settled = 1'b0;
    endtask

    task automatic run_random(input int count);
        fir_pkg::sample_t v;
        for (int n = 0; n < count; n++) begin
            rng_state = xorshift32(rng_state);
            v = fir_pkg::sample_t'(rng_state[17:0]);
            // full-scale extremes now and then
            if (n % 16 == 5) begin
                v = 18'sh1ffff;
            end else if (n % 16 == 11) begin
                v = 18'sh20000;
            end
            apply_sample(v);
        end
    endtask

    a_idle_after_reset : assert property (
        @(posedge sys_clk) disable iff (reset)
        (cyc_after_reset < div - 1) |-> (!sample_strobe && y == '0)
    ) else begin
        ctl_errs++;
        $display("Error at %0t: strobe %0b y %0d before the first strobe", $time,
                 sample_strobe, y);
    end

    a_strobe_period : assert property (
        @(posedge sys_clk) disable iff (reset)
        sample_strobe == ((cyc_after_reset % div) == div - 1)
    ) else begin
        ctl_errs++;
        $display("Error at %0t: strobe %0b in cycle %0d after reset", $time,
                 sample_strobe, cyc_after_reset);
    end

    a_y_holds : assert property (
        @(posedge sys_clk) disable iff (reset)
        !sample_strobe |=> $stable(y)
    ) else begin
        hold_errs++;
        $display("Error at %0t: y moved to %0d without a strobe", $time, y);
    end

    a_model_match : assert property (
        @(posedge sys_clk) disable iff (reset)
        sample_strobe |=> (y == exp_y)
    ) else begin
        model_errs++;
        $display("Error at %0t: y is %0d, model expects %0d", $time, y, exp_y);
    end

    a_impulse : assert property (
        @(posedge sys_clk) disable iff (reset)
        (sample_strobe && imp_active) |=> (y == exp_imp)
    ) else begin
        imp_errs++;
        $display("Error at %0t: impulse response %0d, expected %0d", $time, y, exp_imp);
    end

    a_step_settled : assert property (
        @(posedge sys_clk) disable iff (reset)
        (sample_strobe && step_settled) |=> (y == exp_step)
    ) else begin
        step_errs++;
        $display("Error at %0t: step output %0d, expected %0d", $time, y, exp_step);
    end

    initial begin
        x_in         = '0;
        reset        = 1'b1;
        exp_y        = '0;
        exp_imp      = '0;
        exp_step     = '0;
        imp_active   = 1'b0;
        step_active  = 1'b0;
        step_settled = 1'b0;
        strobe_no    = 0;
        imp_start    = 0;
        step_start   = 0;
        rng_state    = 32'haf36_19ee;
        ctl_errs     = 0;
        hold_errs    = 0;
        model_errs   = 0;
        imp_errs     = 0;
        step_errs    = 0;
        for (int j = 0; j < hist_len; j++) begin
            hist[j] = '0;
        end

        repeat (4) @(posedge sys_clk);
        @(negedge sys_clk);
        reset = 1'b0;

        run_impulse();
        run_step(18'sh0c000);
        run_step(18'sh20000);
        run_random(rand_count);

        // last capture still needs its check edge
        @(posedge sys_clk);
        @(negedge sys_clk);

        total_errs = ctl_errs + hold_errs + model_errs + imp_errs + step_errs;
        $display("errors: control %0d, hold %0d, model %0d, impulse %0d, step %0d, total %0d",
                 ctl_errs, hold_errs, model_errs, imp_errs, step_errs, total_errs);
        if (total_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== fir_sym.f ====
+incdir+rtl
rtl/fir_pkg.sv
rtl/sample_rate_ctl.sv
rtl/fold_delay_line.sv
rtl/tap_adder_tree.sv
rtl/fir_sym_top.sv
test/tb_fir_sym.sv

// ==== Makefile ====
# Verilator build and run for the symmetric FIR

VERILATOR ?= verilator
TOP       ?= tb_fir_sym
FILELIST  ?= fir_sym.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard rtl/*.sv rtl/*.svh test/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "^RESULT: PASS$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
